// File: copper_defines.svh
// copper configuration constants
// sizes shared by the program memory, executor, decoder and palette
// of the display-list coprocessor

`ifndef COPPER_DEFINES_SVH
`define COPPER_DEFINES_SVH

// instruction address width, one entry per 32-bit instruction
// in each of the two memory halves
`define COP_ADDR_W 10

// beam position width, covers both scan line and pixel column
`define COP_POS_W 11

// palette index width, gives 16 colour entries
`define COP_PAL_W 4

`endif

// File: copper_pkg.sv
// copper package
// instruction word, opcode, decoded instruction and palette write
// types shared by the coprocessor blocks

`default_nettype none

`include "copper_defines.svh"

package copper_pkg;

    // one 16-bit half of a copper instruction
    typedef logic [15:0] word_t;

    // opcodes in bits 31..28, any other code runs as END
    typedef enum logic [3:0] {
        END    = 4'd0,
        WAIT_V = 4'd1,
        WAIT_H = 4'd2,
        MOVE   = 4'd3,
        JUMP   = 4'd4
    } cop_op_e;

    // raw instruction as fetched
    // even half is bits 31..16, odd half is bits 15..0
    typedef struct packed {
        logic [3:0]              opcode;
        logic [11-`COP_PAL_W:0]  rsvd;
        logic [`COP_PAL_W-1:0]   pal_idx;
        word_t                   lo;
    } cop_instr_t;

    // instruction with its fields pulled apart
    typedef struct packed {
        cop_op_e                 opcode;
        logic [`COP_POS_W-1:0]   pos;
        logic [`COP_ADDR_W-1:0]  target;
        logic [`COP_PAL_W-1:0]   pal_idx;
        word_t                   data;
    } cop_dec_t;

    // one palette write, valid only while en is high
    typedef struct packed {
        logic                    en;
        logic [`COP_PAL_W-1:0]   idx;
        word_t                   data;
    } pal_wr_t;

endpackage

`default_nettype wire

// File: copper_mem.sv
// copper program memory, one 16-bit half
// two instances (even and odd) together hold the 32-bit instructions
// host writes through its own port, the copper reads through a register

`default_nettype none
`timescale 1ns/1ps

`include "copper_defines.svh"

module copper_mem #(
    parameter EVEN = 1
) (
    input  wire logic                    clk,
    input  wire logic                    wr_en_i,
    input  wire logic [`COP_ADDR_W-1:0]  wr_addr_i,
    input  wire copper_pkg::word_t       wr_data_i,
    input  wire logic                    rd_en_i,
    input  wire logic [`COP_ADDR_W-1:0]  rd_addr_i,
    output copper_pkg::word_t            rd_data_o
);

    // even half carries the opcode, odd half the operand word
    localparam copper_pkg::word_t FILL_WORD = EVEN ?
        copper_pkg::word_t'({copper_pkg::END, 12'h000}) : 16'h0000;

    copper_pkg::word_t bram [0:2**`COP_ADDR_W-1];

    // every slot decodes as END until the host loads a program
    initial begin
        for (int i = 0; i < 2**`COP_ADDR_W; i++) begin
            bram[i] = FILL_WORD;
        end
    end

    // host write port
    always_ff @(posedge clk) begin
        if (wr_en_i) begin
            bram[wr_addr_i] <= wr_data_i;
        end
    end

    // read data holds while rd_en_i is low, so a waiting
    // instruction stays on the decoder input
    always_ff @(posedge clk) begin
        if (rd_en_i) begin
            rd_data_o <= bram[rd_addr_i];
        end
    end

endmodule

`default_nettype wire

// File: copper_decode.sv
// copper instruction decoder
// splits a fetched 32-bit instruction into opcode and operand fields,
// unknown opcodes come out as END

`default_nettype none
`timescale 1ns/1ps

`include "copper_defines.svh"

module copper_decode (
    input  wire copper_pkg::cop_instr_t  instr_i,
    output copper_pkg::cop_dec_t         dec_o
);

    always_comb begin
        // operand fields all come from the low word
        dec_o.pos     = instr_i.lo[`COP_POS_W-1:0];
        dec_o.target  = instr_i.lo[`COP_ADDR_W-1:0];
        dec_o.pal_idx = instr_i.pal_idx;
        dec_o.data    = instr_i.lo;

        case (instr_i.opcode)
            copper_pkg::WAIT_V,
            copper_pkg::WAIT_H,
            copper_pkg::MOVE,
            copper_pkg::JUMP: begin
                dec_o.opcode = copper_pkg::cop_op_e'(instr_i.opcode);
            end
            // skip, compare and spare codes stop the list
            default: begin
                dec_o.opcode = copper_pkg::END;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: copper_exec.sv
// copper executor
// program counter and fetch/execute FSM, run once per frame from
// address 0, waits on beam position and issues palette writes

`default_nettype none
`timescale 1ns/1ps

`include "copper_defines.svh"

module copper_exec (
    input  wire logic                    clk,
    input  wire logic                    rst_i,
    input  wire logic                    cop_en_i,
    input  wire logic                    frame_start_i,
    input  wire logic [`COP_POS_W-1:0]   h_pos_i,
    input  wire logic [`COP_POS_W-1:0]   v_pos_i,
    input  wire copper_pkg::cop_dec_t    dec_i,
    output logic                         rd_en_o,
    output logic [`COP_ADDR_W-1:0]       rd_addr_o,
    output copper_pkg::pal_wr_t          pal_wr_o
);

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        EXEC
    } state_t;

    state_t                  state;
    state_t                  state_d;
    logic [`COP_ADDR_W-1:0]  pc;
    logic [`COP_ADDR_W-1:0]  pc_d;
    logic                    wait_met;
    logic                    move_req;

    // one read per instruction, data arrives as EXEC starts
    assign rd_en_o   = (state == FETCH);
    assign rd_addr_o = pc;

    // wait released once the beam has reached the position field
    always_comb begin
        case (dec_i.opcode)
            copper_pkg::WAIT_V: wait_met = (v_pos_i >= dec_i.pos);
            copper_pkg::WAIT_H: wait_met = (h_pos_i >= dec_i.pos);
            default:            wait_met = 1'b0;
        endcase
    end

    always_comb begin
        state_d  = state;
        pc_d     = pc;
        move_req = 1'b0;

        case (state)
            IDLE: begin
                state_d = IDLE;
            end
            FETCH: begin
                state_d = EXEC;
            end
            EXEC: begin
                case (dec_i.opcode)
                    copper_pkg::WAIT_V,
                    copper_pkg::WAIT_H: begin
                        if (wait_met) begin
                            pc_d    = pc + 1'b1;
                            state_d = FETCH;
                        end
                    end
                    copper_pkg::MOVE: begin
                        move_req = 1'b1;
                        pc_d     = pc + 1'b1;
                        state_d  = FETCH;
                    end
                    copper_pkg::JUMP: begin
                        pc_d    = dec_i.target;
                        state_d = FETCH;
                    end
                    default: begin
                        // END, wait for the next frame
                        state_d = IDLE;
                    end
                endcase
            end
            default: begin
                state_d = IDLE;
            end
        endcase

        // frame start abandons the current instruction
        if (frame_start_i) begin
            state_d  = FETCH;
            pc_d     = '0;
            move_req = 1'b0;
        end

        if (!cop_en_i) begin
            state_d  = IDLE;
            move_req = 1'b0;
        end
    end

    // palette write is a one-cycle pulse during the MOVE's EXEC cycle
    always_comb begin
        pal_wr_o.en   = move_req;
        pal_wr_o.idx  = dec_i.pal_idx;
        pal_wr_o.data = dec_i.data;
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            state <= IDLE;
            pc    <= '0;
        end else begin
            state <= state_d;
            pc    <= pc_d;
        end
    end

endmodule

`default_nettype wire

// File: copper_palette.sv
// colour palette
// 16 entries of 16 bits, written by copper MOVEs and cleared on reset,
// read through a register so a write shows two cycles later

`default_nettype none
`timescale 1ns/1ps

`include "copper_defines.svh"

module copper_palette (
    input  wire logic                    clk,
    input  wire logic                    rst_i,
    input  wire copper_pkg::pal_wr_t     pal_wr_i,
    input  wire logic [`COP_PAL_W-1:0]   rd_idx_i,
    output copper_pkg::word_t            rd_data_o
);

    localparam int PAL_SIZE = 2**`COP_PAL_W;

    copper_pkg::word_t pal [0:PAL_SIZE-1];

    // register array, every entry goes back to black on reset
    always_ff @(posedge clk) begin
        if (rst_i) begin
            for (int i = 0; i < PAL_SIZE; i++) begin
                pal[i] <= '0;
            end
        end else if (pal_wr_i.en) begin
            pal[pal_wr_i.idx] <= pal_wr_i.data;
        end
    end

    // read register samples the array after the write edge
    always_ff @(posedge clk) begin
        rd_data_o <= pal[rd_idx_i];
    end

endmodule

`default_nettype wire

// File: copper_top.sv
// copper top level
// two program memory halves, decoder, executor and palette,
// host writes go to the even or odd half by address bit 0

`default_nettype none
`timescale 1ns/1ps

`include "copper_defines.svh"

module copper_top (
    input  wire logic                    clk,
    input  wire logic                    rst_i,
    input  wire logic                    cop_en_i,
    input  wire logic                    frame_start_i,
    input  wire logic [`COP_POS_W-1:0]   h_pos_i,
    input  wire logic [`COP_POS_W-1:0]   v_pos_i,
    input  wire logic                    wr_en_i,
    input  wire logic [`COP_ADDR_W:0]    wr_addr_i,
    input  wire copper_pkg::word_t       wr_data_i,
    input  wire logic [`COP_PAL_W-1:0]   pal_idx_i,
    output copper_pkg::word_t            pal_data_o
);

    logic                    even_we;
    logic                    odd_we;
    logic [`COP_ADDR_W-1:0]  wr_word_addr;
    copper_pkg::word_t       even_rd_data;
    copper_pkg::word_t       odd_rd_data;
    copper_pkg::cop_instr_t  instr;
    copper_pkg::cop_dec_t    dec;
    logic                    rd_en;
    logic [`COP_ADDR_W-1:0]  rd_addr;
    copper_pkg::pal_wr_t     pal_wr;

    // host address is in half-words, bit 0 picks odd or even
    assign wr_word_addr = wr_addr_i[`COP_ADDR_W:1];
    assign even_we      = wr_en_i & ~wr_addr_i[0];
    assign odd_we       = wr_en_i & wr_addr_i[0];

    // even half is the upper word of the instruction
    assign instr = {even_rd_data, odd_rd_data};

    copper_mem #(.EVEN(1)) u_mem_even (
        .clk       (clk),
        .wr_en_i   (even_we),
        .wr_addr_i (wr_word_addr),
        .wr_data_i (wr_data_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (even_rd_data)
    );

    copper_mem #(.EVEN(0)) u_mem_odd (
        .clk       (clk),
        .wr_en_i   (odd_we),
        .wr_addr_i (wr_word_addr),
        .wr_data_i (wr_data_i),
        .rd_en_i   (rd_en),
        .rd_addr_i (rd_addr),
        .rd_data_o (odd_rd_data)
    );

    copper_decode u_decode (
        .instr_i (instr),
        .dec_o   (dec)
    );

    copper_exec u_exec (
        .clk           (clk),
        .rst_i         (rst_i),
        .cop_en_i      (cop_en_i),
        .frame_start_i (frame_start_i),
        .h_pos_i       (h_pos_i),
        .v_pos_i       (v_pos_i),
        .dec_i         (dec),
        .rd_en_o       (rd_en),
        .rd_addr_o     (rd_addr),
        .pal_wr_o      (pal_wr)
    );

    copper_palette u_palette (
        .clk       (clk),
        .rst_i     (rst_i),
        .pal_wr_i  (pal_wr),
        .rd_idx_i  (pal_idx_i),
        .rd_data_o (pal_data_o)
    );

endmodule

`default_nettype wire

// File: copper_tb.sv
// copper testbench
// loads a display list through the host port, runs it against a
// driven beam position and checks the palette through its read port

`default_nettype none
`timescale 1ns/1ps

`include "copper_defines.svh"

module copper_tb;

    localparam int PROG_LEN      = 12;
    localparam int NUM_STEPS     = 16;
    localparam int NUM_WORDS     = 10;
    localparam int SETTLE_CYCLES = 2 * PROG_LEN + 8;
    localparam int POLL_TIMEOUT  = 100;
    localparam int PAL_SIZE      = 2**`COP_PAL_W;

    // opcodes as the instruction format defines them
    localparam logic [3:0] OP_END    = 4'd0;
    localparam logic [3:0] OP_WAIT_V = 4'd1;
    localparam logic [3:0] OP_WAIT_H = 4'd2;
    localparam logic [3:0] OP_MOVE   = 4'd3;
    localparam logic [3:0] OP_JUMP   = 4'd4;

    // what a step does before its palette check
    localparam logic [1:0] ACT_NONE  = 2'd0;
    localparam logic [1:0] ACT_FRAME = 2'd1;
    localparam logic [1:0] ACT_PATCH = 2'd2;

    // arg is the data word select for MOVE, else position or target
    typedef struct packed {
        logic [3:0]              op;
        logic [`COP_PAL_W-1:0]   idx;
        logic [15:0]             arg;
    } prog_row_t;

    // same set means the entry must keep its previous value
    typedef struct packed {
        logic [2:0]              test;
        logic [1:0]              act;
        logic                    en;
        logic [`COP_POS_W-1:0]   v_pos;
        logic [`COP_POS_W-1:0]   h_pos;
        logic [`COP_ADDR_W-1:0]  patch_addr;
        logic [`COP_PAL_W-1:0]   idx;
        logic                    same;
        logic [3:0]              sel;
    } step_t;

    logic                    clk;
    logic                    rst_i;
    logic                    cop_en_i;
    logic                    frame_start_i;
    logic [`COP_POS_W-1:0]   h_pos_i;
    logic [`COP_POS_W-1:0]   v_pos_i;
    logic                    wr_en_i;
    logic [`COP_ADDR_W:0]    wr_addr_i;
    logic [15:0]             wr_data_i;
    logic [`COP_PAL_W-1:0]   pal_idx_i;
    logic [15:0]             pal_data_o;

    prog_row_t               prog [0:PROG_LEN-1];
    step_t                   steps [0:NUM_STEPS-1];
    logic [15:0]             data_words [0:NUM_WORDS-1];
    logic [15:0]             pal_model [0:PAL_SIZE-1];
    logic [15:0]             lfsr;
    int                      total_checks;
    int                      total_errors;
    int                      test_checks [1:6];
    int                      test_errors [1:6];
    string                   test_name [1:6];

    copper_top UUT (
        .clk           (clk),
        .rst_i         (rst_i),
        .cop_en_i      (cop_en_i),
        .frame_start_i (frame_start_i),
        .h_pos_i       (h_pos_i),
        .v_pos_i       (v_pos_i),
        .wr_en_i       (wr_en_i),
        .wr_addr_i     (wr_addr_i),
        .wr_data_i     (wr_data_i),
        .pal_idx_i     (pal_idx_i),
        .pal_data_o    (pal_data_o)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        lfsr_next = {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
    endfunction

    // even word is opcode and index, odd word is the operand
    function automatic logic [31:0] encode_instr(input logic [3:0] op,
                                                 input logic [`COP_PAL_W-1:0] idx,
                                                 input logic [15:0] lo);
        encode_instr = {op, {(12 - `COP_PAL_W){1'b0}}, idx, lo};
    endfunction

    // one LFSR step per bit taken
    task automatic random_word(output logic [15:0] w);
        w = '0;
        for (int b = 0; b < 16; b++) begin
            lfsr = lfsr_next(lfsr);
            w = {w[14:0], lfsr[0]};
        end
    endtask

    task automatic write_instr(input logic [`COP_ADDR_W-1:0] addr, input logic [31:0] instr);
        @(negedge clk);
        wr_en_i   = 1'b1;
        wr_addr_i = {addr, 1'b0};
        wr_data_i = instr[31:16];
        @(negedge clk);
        wr_addr_i = {addr, 1'b1};
        wr_data_i = instr[15:0];
        @(negedge clk);
        wr_en_i   = 1'b0;
    endtask

    task automatic load_program();
        logic [15:0] lo;
        for (int a = 0; a < PROG_LEN; a++) begin
            if (prog[a].op == OP_MOVE) begin
                lo = data_words[prog[a].arg[3:0]];
            end else begin
                lo = prog[a].arg;
            end
            write_instr(a[`COP_ADDR_W-1:0], encode_instr(prog[a].op, prog[a].idx, lo));
        end
    endtask

    task automatic pulse_frame();
        @(negedge clk);
        frame_start_i = 1'b1;
        @(negedge clk);
        frame_start_i = 1'b0;
    endtask

    // poll for an expected write, or let the program settle for an unchanged entry
    task automatic check_entry(input logic [`COP_PAL_W-1:0] idx, input logic [15:0] exp,
                               input logic poll, input int t);
        int   n;
        logic hit;
        n   = 0;
        hit = 1'b0;
        @(negedge clk);
        pal_idx_i = idx;
        if (poll) begin
            while (!hit && n < POLL_TIMEOUT) begin
                @(negedge clk);
                n++;
                if (pal_data_o === exp) begin
                    hit = 1'b1;
                end
            end
            if (!hit) begin
                $display("timeout after %0d cycles waiting for palette entry %0d", n, idx);
            end
        end else begin
            while (n < SETTLE_CYCLES) begin
                @(negedge clk);
                n++;
            end
        end
        total_checks++;
        test_checks[t]++;
        if (pal_data_o !== exp) begin
            $display("FAILED at %0d ns: pal_data_o[%0d] = %h, expected %h",
                     $time, idx, pal_data_o, exp);
            total_errors++;
            test_errors[t]++;
        end
    endtask

    task automatic check_all_clear(input int t);
        for (int i = 0; i < PAL_SIZE; i++) begin
            check_entry(i[`COP_PAL_W-1:0], 16'h0000, 1'b0, t);
        end
    endtask

    task automatic report_test(input int t);
        $display("test %0d (%s): %0d checks, %0d errors",
                 t, test_name[t], test_checks[t], test_errors[t]);
    endtask

    task automatic fill_tables();
        for (int w = 0; w < NUM_WORDS; w++) begin
            random_word(data_words[w]);
        end
        prog[0]  = {OP_MOVE,   4'd0, 16'd0};
        prog[1]  = {OP_MOVE,   4'd1, 16'd1};
        prog[2]  = {OP_MOVE,   4'd2, 16'd2};
        prog[3]  = {OP_MOVE,   4'd3, 16'd3};
        prog[4]  = {OP_JUMP,   4'd0, 16'd6};
        // skipped by the jump
        prog[5]  = {OP_MOVE,   4'd4, 16'd4};
        prog[6]  = {OP_MOVE,   4'd5, 16'd5};
        prog[7]  = {OP_WAIT_V, 4'd0, 16'd100};
        prog[8]  = {OP_MOVE,   4'd6, 16'd6};
        prog[9]  = {OP_WAIT_H, 4'd0, 16'd200};
        prog[10] = {OP_MOVE,   4'd7, 16'd7};
        prog[11] = {OP_END,    4'd0, 16'd0};
        // test, action, en, v_pos, h_pos, patch addr, idx, same, sel
        steps[0]  = {3'd2, ACT_FRAME, 1'b1, 11'd0,   11'd0,   10'd0, 4'd0, 1'b0, 4'd0};
        steps[1]  = {3'd2, ACT_NONE,  1'b1, 11'd0,   11'd0,   10'd0, 4'd1, 1'b0, 4'd1};
        steps[2]  = {3'd2, ACT_NONE,  1'b1, 11'd0,   11'd0,   10'd0, 4'd2, 1'b0, 4'd2};
        steps[3]  = {3'd2, ACT_NONE,  1'b1, 11'd0,   11'd0,   10'd0, 4'd3, 1'b0, 4'd3};
        steps[4]  = {3'd3, ACT_NONE,  1'b1, 11'd0,   11'd0,   10'd0, 4'd6, 1'b1, 4'd0};
        steps[5]  = {3'd3, ACT_NONE,  1'b1, 11'd99,  11'd0,   10'd0, 4'd6, 1'b1, 4'd0};
        steps[6]  = {3'd3, ACT_NONE,  1'b1, 11'd100, 11'd0,   10'd0, 4'd6, 1'b0, 4'd6};
        steps[7]  = {3'd4, ACT_NONE,  1'b1, 11'd100, 11'd0,   10'd0, 4'd7, 1'b1, 4'd0};
        steps[8]  = {3'd4, ACT_NONE,  1'b1, 11'd100, 11'd199, 10'd0, 4'd7, 1'b1, 4'd0};
        steps[9]  = {3'd4, ACT_NONE,  1'b1, 11'd100, 11'd200, 10'd0, 4'd7, 1'b0, 4'd7};
        steps[10] = {3'd5, ACT_NONE,  1'b1, 11'd100, 11'd200, 10'd0, 4'd4, 1'b1, 4'd0};
        steps[11] = {3'd5, ACT_NONE,  1'b1, 11'd100, 11'd200, 10'd0, 4'd5, 1'b0, 4'd5};
        steps[12] = {3'd5, ACT_PATCH, 1'b1, 11'd100, 11'd200, 10'd0, 4'd0, 1'b1, 4'd8};
        steps[13] = {3'd5, ACT_FRAME, 1'b1, 11'd100, 11'd200, 10'd0, 4'd0, 1'b0, 4'd8};
        steps[14] = {3'd6, ACT_PATCH, 1'b0, 11'd100, 11'd200, 10'd1, 4'd1, 1'b1, 4'd9};
        steps[15] = {3'd6, ACT_FRAME, 1'b0, 11'd100, 11'd200, 10'd0, 4'd1, 1'b1, 4'd0};
    endtask

    initial begin
        step_t       s;
        logic [15:0] exp;
        rst_i         = 1'b1;
        cop_en_i      = 1'b0;
        frame_start_i = 1'b0;
        h_pos_i       = '0;
        v_pos_i       = '0;
        wr_en_i       = 1'b0;
        wr_addr_i     = '0;
        wr_data_i     = '0;
        pal_idx_i     = '0;
        lfsr          = 16'd17223;
        total_checks  = 0;
        total_errors  = 0;
        test_name[1]  = "reset and load leave palette clear";
        test_name[2]  = "move writes";
        test_name[3]  = "wait on v_pos";
        test_name[4]  = "wait on h_pos";
        test_name[5]  = "jump, end and rerun";
        test_name[6]  = "copper disabled";
        for (int t = 1; t <= 6; t++) begin
            test_checks[t] = 0;
            test_errors[t] = 0;
        end
        for (int i = 0; i < PAL_SIZE; i++) begin
            pal_model[i] = '0;
        end
        fill_tables();

        repeat (10) @(negedge clk);
        rst_i    = 1'b0;
        cop_en_i = 1'b1;

        check_all_clear(1);
        load_program();
        check_all_clear(1);
        report_test(1);

        for (int i = 0; i < NUM_STEPS; i++) begin
            s = steps[i];
            @(negedge clk);
            cop_en_i = s.en;
            v_pos_i  = s.v_pos;
            h_pos_i  = s.h_pos;
            if (s.act == ACT_PATCH) begin
                write_instr(s.patch_addr, encode_instr(OP_MOVE, s.idx, data_words[s.sel]));
            end
            if (s.act == ACT_FRAME) begin
                pulse_frame();
            end
            if (s.same) begin
                exp = pal_model[s.idx];
            end else begin
                exp = data_words[s.sel];
                pal_model[s.idx] = exp;
            end
            check_entry(s.idx, exp, !s.same, int'(s.test));
            if (i == NUM_STEPS - 1) begin
                report_test(int'(s.test));
            end else if (steps[i + 1].test != s.test) begin
                report_test(int'(s.test));
            end
        end

        $display("%0d checks, %0d errors", total_checks, total_errors);
        if (total_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: tb.f
+incdir+.
copper_pkg.sv
copper_mem.sv
copper_decode.sv
copper_exec.sv
copper_palette.sv
copper_top.sv
copper_tb.sv

// File: run.sh
#!/usr/bin/env bash
# build the copper testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing -j 0 --top-module copper_tb -f tb.f -o copper_sim \
    && ./obj_dir/copper_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }

cat sim.log
grep -q "Test failed" sim.log && exit 1 || exit 0
